/* include/sysctl_cfg.svh */
`ifndef SYSCTL_CFG_SVH
`define SYSCTL_CFG_SVH

//----------------------------------------
// CSR bus geometry
//----------------------------------------
`define CSR_ADDR_W      14
`define CSR_DATA_W      32
// Upper 4 address bits pick the controller
`define SYSCTL_BANK     4'h1

//----------------------------------------
// Register offsets, lower 10 address bits
//----------------------------------------
// Button state, read only
`define REG_GPIO_IN     10'd0
`define REG_GPIO_OUT    10'd1
`define REG_GPIO_IRQEN  10'd2
// Timer 0
`define REG_T0_CTRL     10'd3
`define REG_T0_CMP      10'd4
`define REG_T0_CNT      10'd5
// Timer 1
`define REG_T1_CTRL     10'd6
`define REG_T1_CMP      10'd7
`define REG_T1_CNT      10'd8
// Identity word, read only
`define REG_SYSID       10'd9

//----------------------------------------
// Sizes and constants
//----------------------------------------
`define GPIO_NIN        3
`define GPIO_NOUT       2
// "SYCT"
`define SYSTEM_ID       32'h53594354
// 6 bits give a 63 cycle stretch
`define ACT_STRETCH_W   6

`endif

/* hw/sysctl_pkg.sv */
`include "sysctl_cfg.svh"

package sysctl_pkg;

	//----------------------------------------
	// APB slave port
	//----------------------------------------
	// Master to slave
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		// Byte address, two low bits ignored
		logic [`CSR_ADDR_W+1:0] paddr;
		logic [`CSR_DATA_W-1:0] pwdata;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		logic                   pready;
		logic [`CSR_DATA_W-1:0] prdata;
	} apb_rsp_t;

	//----------------------------------------
	// CSR bus
	//----------------------------------------
	// Word address, write strobe and write data
	typedef struct packed {
		logic [`CSR_ADDR_W-1:0] csr_a;
		logic                   csr_we;
		logic [`CSR_DATA_W-1:0] csr_dw;
	} csr_req_t;

	//----------------------------------------
	// Interrupt lines
	//----------------------------------------
	// One-cycle pulses
	typedef struct packed {
		logic gpio;
		logic timer0;
		logic timer1;
	} irq_t;

endpackage

/* hw/apb_csr_bridge.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module apb_csr_bridge (
	input  logic                   sys_clk,
	input  logic                   rst1,
	input  sysctl_pkg::apb_req_t   apb_i,
	output sysctl_pkg::apb_rsp_t   apb_o,
	output sysctl_pkg::csr_req_t   csr_o,
	input  logic [`CSR_DATA_W-1:0] csr_dr_i
);
	import sysctl_pkg::*;

	// Idle, request on the CSR bus, answer the master
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_RESPOND
	} state_t;

	state_t   state;
	csr_req_t csr_q;

	//----------------------------------------
	// Transfer sequencing
	//----------------------------------------
	// Fixed two wait states per transfer
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				// Wait for an access phase
				ST_IDLE:
					if (apb_i.psel && apb_i.penable)
						state <= ST_ISSUE;
				// Request is on the bus this cycle
				ST_ISSUE:
					state <= ST_RESPOND;
				// pready for one cycle, then back
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	//----------------------------------------
	// CSR request register
	//----------------------------------------
	// Write strobe lives for the issue cycle only
	always_ff @(posedge sys_clk) begin
		if (!rst1)
			csr_q.csr_we <= 1'b0;
		else
			csr_q.csr_we <= (state == ST_IDLE) && apb_i.psel && apb_i.penable && apb_i.pwrite;
	end

	// Address and data latched on entry, held otherwise
	always_ff @(posedge sys_clk) begin
		if ((state == ST_IDLE) && apb_i.psel && apb_i.penable) begin
			// Byte to word address
			csr_q.csr_a  <= apb_i.paddr[`CSR_ADDR_W+1:2];
			csr_q.csr_dw <= apb_i.pwdata;
		end
	end

	assign csr_o = csr_q;

	// Read data from the blocks arrives with the respond state
	always_comb begin
		apb_o.pready = (state == ST_RESPOND);
		apb_o.prdata = (state == ST_RESPOND) ? csr_dr_i : '0;
	end

endmodule

/* hw/sysctl_timer.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module sysctl_timer (
	input  logic                   sys_clk,
	input  logic                   rst1,
	input  sysctl_pkg::csr_req_t   csr_i,
	output logic [`CSR_DATA_W-1:0] csr_dr_o,
	output logic                   timer0_irq_o,
	output logic                   timer1_irq_o
);

	// Per-timer register offsets
	localparam logic [9:0] CTRL_OFF [2] = '{`REG_T0_CTRL, `REG_T1_CTRL};
	localparam logic [9:0] CMP_OFF  [2] = '{`REG_T0_CMP, `REG_T1_CMP};
	localparam logic [9:0] CNT_OFF  [2] = '{`REG_T0_CNT, `REG_T1_CNT};

	logic                   bank_sel;
	logic [9:0]             off;
	logic                   csr_wr;
	// Control bits
	logic                   tm_en  [2];
	logic                   tm_ar  [2];
	logic                   tm_irq [2];
	logic [`CSR_DATA_W-1:0] tm_cmp [2];
	logic [`CSR_DATA_W-1:0] tm_cnt [2];

	//----------------------------------------
	// Address decode
	//----------------------------------------
	assign bank_sel = (csr_i.csr_a[`CSR_ADDR_W-1 -: 4] == `SYSCTL_BANK);
	assign off      = csr_i.csr_a[9:0];
	assign csr_wr   = csr_i.csr_we && bank_sel;

	//----------------------------------------
	// Counters and control
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			for (int i = 0; i < 2; i++) begin
				tm_en[i]  <= 1'b0;
				tm_ar[i]  <= 1'b0;
				tm_irq[i] <= 1'b0;
				tm_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				tm_irq[i] <= 1'b0;
				if (tm_en[i]) begin
					if (tm_cnt[i] == tm_cmp[i]) begin
						// Match: pulse, wrap, stop unless auto-restart
						tm_cnt[i] <= '0;
						tm_irq[i] <= 1'b1;
						tm_en[i]  <= tm_ar[i];
					end else begin
						tm_cnt[i] <= tm_cnt[i] + 1'b1;
					end
				end
				// CPU writes take priority over the count
				if (csr_wr && (off == CTRL_OFF[i])) begin
					tm_en[i] <= csr_i.csr_dw[0];
					tm_ar[i] <= csr_i.csr_dw[1];
				end
				// Counter preload
				if (csr_wr && (off == CNT_OFF[i]))
					tm_cnt[i] <= csr_i.csr_dw;
			end
		end
	end

	// Compare values
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 2; i++)
			if (csr_wr && (off == CMP_OFF[i]))
				tm_cmp[i] <= csr_i.csr_dw;
	end

	//----------------------------------------
	// Read back
	//----------------------------------------
	// Zero for any address outside this block
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (bank_sel) begin
			for (int i = 0; i < 2; i++) begin
				if (off == CTRL_OFF[i])
					csr_dr_o <= {30'd0, tm_ar[i], tm_en[i]};
				if (off == CMP_OFF[i])
					csr_dr_o <= tm_cmp[i];
				if (off == CNT_OFF[i])
					csr_dr_o <= tm_cnt[i];
			end
		end
	end

	assign timer0_irq_o = tm_irq[0];
	assign timer1_irq_o = tm_irq[1];

endmodule

/* hw/sysctl_gpio.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module sysctl_gpio (
	input  logic                   sys_clk,
	input  logic                   rst1,
	input  sysctl_pkg::csr_req_t   csr_i,
	output logic [`CSR_DATA_W-1:0] csr_dr_o,
	input  logic [`GPIO_NIN-1:0]   gpio_in_i,
	output logic [`GPIO_NOUT-1:0]  gpio_out_o,
	output logic                   gpio_irq_o
);

	logic                  bank_sel;
	logic [9:0]            off;
	logic                  csr_wr;
	// Two-flop synchroniser, then previous sample
	logic [`GPIO_NIN-1:0]  in_s1;
	logic [`GPIO_NIN-1:0]  in_s2;
	logic [`GPIO_NIN-1:0]  in_prev;
	logic [`GPIO_NIN-1:0]  irq_en;

	assign bank_sel = (csr_i.csr_a[`CSR_ADDR_W-1 -: 4] == `SYSCTL_BANK);
	assign off      = csr_i.csr_a[9:0];
	assign csr_wr   = csr_i.csr_we && bank_sel;

	//----------------------------------------
	// Inputs and change interrupt
	//----------------------------------------
	// Pulse lands 3 cycles after the pin moves
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			in_s1      <= '0;
			in_s2      <= '0;
			in_prev    <= '0;
			gpio_irq_o <= 1'b0;
		end else begin
			in_s1      <= gpio_in_i;
			in_s2      <= in_s1;
			in_prev    <= in_s2;
			// Any edge on an enabled input
			gpio_irq_o <= |((in_s2 ^ in_prev) & irq_en);
		end
	end

	//----------------------------------------
	// Writable registers
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			gpio_out_o <= '0;
			irq_en     <= '0;
		end else if (csr_wr) begin
			if (off == `REG_GPIO_OUT)
				gpio_out_o <= csr_i.csr_dw[`GPIO_NOUT-1:0];
			if (off == `REG_GPIO_IRQEN)
				irq_en <= csr_i.csr_dw[`GPIO_NIN-1:0];
		end
	end

	// Read mux, unused offsets give zero
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (bank_sel) begin
			case (off)
				`REG_GPIO_IN:    csr_dr_o[`GPIO_NIN-1:0]  <= in_s2;
				`REG_GPIO_OUT:   csr_dr_o[`GPIO_NOUT-1:0] <= gpio_out_o;
				`REG_GPIO_IRQEN: csr_dr_o[`GPIO_NIN-1:0]  <= irq_en;
				`REG_SYSID:      csr_dr_o                 <= `SYSTEM_ID;
				default:         csr_dr_o                 <= '0;
			endcase
		end
	end

endmodule

/* hw/activity_led.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module activity_led (
	input  logic       sys_clk,
	input  logic       rst1,
	// Bit 0 transmit, bit 1 receive
	input  logic [1:0] line_i,
	output logic [1:0] led_o
);

	logic [`ACT_STRETCH_W-1:0] stretch_cnt [2];

	//----------------------------------------
	// Pulse stretchers
	//----------------------------------------
	// Idle lines sit high, a start bit pulls them low
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			for (int i = 0; i < 2; i++)
				stretch_cnt[i] <= '0;
			led_o <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// Low line reloads to all ones
				if (!line_i[i])
					stretch_cnt[i] <= '1;
				else if (stretch_cnt[i] != '0)
					stretch_cnt[i] <= stretch_cnt[i] - 1'b1;
				// LED lags the counter by one cycle
				led_o[i] <= (stretch_cnt[i] != '0);
			end
		end
	end

endmodule

/* hw/sysctl_top.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module sysctl_top (
	input  logic                  sys_clk,
	input  logic                  rst1,
	input  sysctl_pkg::apb_req_t  apb_i,
	output sysctl_pkg::apb_rsp_t  apb_o,
	input  logic [`GPIO_NIN-1:0]  gpio_in_i,
	output logic [`GPIO_NOUT-1:0] gpio_out_o,
	input  logic                  uart_rxd_i,
	input  logic                  uart_txd_i,
	output logic [1:0]            act_led_o,
	output sysctl_pkg::irq_t      irq_o
);
	import sysctl_pkg::*;

	//----------------------------------------
	// CSR bus
	//----------------------------------------
	csr_req_t               csr_req;
	logic [`CSR_DATA_W-1:0] csr_dr_timer;
	logic [`CSR_DATA_W-1:0] csr_dr_gpio;

	// APB to CSR
	apb_csr_bridge u_bridge (
		.sys_clk  (sys_clk),
		.rst1     (rst1),
		.apb_i    (apb_i),
		.apb_o    (apb_o),
		.csr_o    (csr_req),
		// Unselected blocks return zero, so OR the lines
		.csr_dr_i (csr_dr_timer | csr_dr_gpio)
	);

	//----------------------------------------
	// System controller blocks
	//----------------------------------------
	sysctl_timer u_timer (
		.sys_clk      (sys_clk),
		.rst1         (rst1),
		.csr_i        (csr_req),
		.csr_dr_o     (csr_dr_timer),
		.timer0_irq_o (irq_o.timer0),
		.timer1_irq_o (irq_o.timer1)
	);

	sysctl_gpio u_gpio (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.csr_i      (csr_req),
		.csr_dr_o   (csr_dr_gpio),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.gpio_irq_o (irq_o.gpio)
	);

	// Serial activity LEDs, transmit on bit 0
	activity_led u_act_led (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.line_i  ({uart_rxd_i, uart_txd_i}),
		.led_o   (act_led_o)
	);

endmodule

/* verification/tb_sysctl.sv */
`timescale 1ns/100ps
`include "sysctl_cfg.svh"

module tb_sysctl;
	import sysctl_pkg::*;

	// Watchdog budget is twice the transfers plus waits
	localparam int N_XFERS   = 70;
	localparam int N_WAITS   = 520;
	localparam int WDOG_CYC  = 2 * (6 * N_XFERS + N_WAITS);
	localparam int XFER_LIM  = 16;
	// Stretch length in lit cycles
	localparam int STRETCH   = (1 << `ACT_STRETCH_W) - 1;
	localparam logic [31:0] OUT_MASK  = (32'd1 << `GPIO_NOUT) - 1;
	localparam logic [31:0] EN_MASK   = (32'd1 << `GPIO_NIN) - 1;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic                  sys_clk;
	logic                  rst1;
	apb_req_t              apb_req;
	apb_rsp_t              apb_rsp;
	logic [`GPIO_NIN-1:0]  gpio_in;
	logic [`GPIO_NOUT-1:0] gpio_out;
	logic                  uart_rxd;
	logic                  uart_txd;
	logic [1:0]            act_led;
	irq_t                  irq;

	logic [31:0] lfsr_state;
	string       cur_test;
	int          err_cnt;
	int          test_err_base;
	int          test_cnt;
	int          test_fail_cnt;
	// Interrupt pulse counts
	int          gpio_irq_cnt;
	int          tmr_irq_cnt [2];

	sysctl_top u_sysctl_top (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.apb_i      (apb_req),
		.apb_o      (apb_rsp),
		.gpio_in_i  (gpio_in),
		.gpio_out_o (gpio_out),
		.uart_rxd_i (uart_rxd),
		.uart_txd_i (uart_txd),
		.act_led_o  (act_led),
		.irq_o      (irq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// Sampled mid-cycle away from the active edge
	always @(negedge sys_clk) begin
		if (irq.gpio)
			gpio_irq_cnt++;
		if (irq.timer0)
			tmr_irq_cnt[0]++;
		if (irq.timer1)
			tmr_irq_cnt[1]++;
	end

	// pready is a single-cycle strobe
	pready_pulse: assert property (@(posedge sys_clk) disable iff (!rst1)
		apb_rsp.pready |=> !apb_rsp.pready)
	else begin
		err_cnt++;
		$display("pready stayed high for more than one cycle");
	end

	initial begin
		repeat (WDOG_CYC) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, run did not complete", WDOG_CYC);
		$display("CHECKS FAILED");
		$finish;
	end

	//----------------------------------------
	// Helpers
	//----------------------------------------
	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] next_rand(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < nbits; b++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
			else
				lfsr_state = lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] reg_addr(input logic [9:0] off);
		return {`SYSCTL_BANK, off, 2'b00};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#10;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			err_cnt++;
			$display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			err_cnt++;
			$display("%s: %s", cur_test, msg);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test      = name;
		test_err_base = err_cnt;
		test_cnt++;
	endtask

	task automatic end_test();
		int n;
		n = err_cnt - test_err_base;
		if (n != 0)
			test_fail_cnt++;
		$display("test %s: %s, %0d error(s)", cur_test, (n == 0) ? "ok" : "fail", n);
	endtask

	//----------------------------------------
	// APB master
	//----------------------------------------
	task automatic apb_transfer(input logic wr, input logic [15:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		// Setup phase
		@(posedge sys_clk);
		#10;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		// Access phase held until the slave answers
		@(posedge sys_clk);
		#10;
		apb_req.penable = 1'b1;
		@(negedge sys_clk);
		while (!apb_rsp.pready && waited < XFER_LIM) begin
			@(negedge sys_clk);
			waited++;
		end
		if (apb_rsp.pready) begin
			rdata = apb_rsp.prdata;
		end else begin
			err_cnt++;
			$display("%s: no pready within %0d cycles at address %h", cur_test, XFER_LIM, addr);
		end
		@(posedge sys_clk);
		#10;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
	endtask

	task automatic write_reg(input logic [9:0] off, input logic [31:0] data);
		logic [31:0] unused;
		apb_transfer(1'b1, reg_addr(off), data, unused);
	endtask

	task automatic read_reg(input logic [9:0] off, output logic [31:0] data);
		apb_transfer(1'b0, reg_addr(off), 32'd0, data);
	endtask

	// Counts negedges until the timer pulse or the limit
	task automatic wait_pulse(input int i, input int limit, output int waited,
			output logic seen);
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < limit) begin
			@(negedge sys_clk);
			waited++;
			seen = (i == 0) ? irq.timer0 : irq.timer1;
		end
	endtask

	//----------------------------------------
	// Tests
	//----------------------------------------
	task automatic reset_test();
		logic [31:0] rd;
		begin_test("reset");
		idle_cycles(1);
		check_value("pready", 32'd0, 32'(apb_rsp.pready));
		check_value("irq", 32'd0, 32'(irq));
		check_value("act_led", 32'd0, 32'(act_led));
		check_value("gpio_out", 32'd0, 32'(gpio_out));
		read_reg(`REG_T0_CNT, rd);
		check_value("T0_CNT", 32'd0, rd);
		read_reg(`REG_T1_CNT, rd);
		check_value("T1_CNT", 32'd0, rd);
		read_reg(`REG_T0_CTRL, rd);
		check_value("T0_CTRL", 32'd0, rd);
		end_test();
	endtask

	task automatic roundtrip_test();
		logic [31:0] rd;
		logic [31:0] wv;
		begin_test("roundtrip");
		for (int n = 0; n < 4; n++) begin
			wv = next_rand(32);
			write_reg(`REG_GPIO_OUT, wv);
			check_value("gpio_out pins", wv & OUT_MASK, 32'(gpio_out));
			read_reg(`REG_GPIO_OUT, rd);
			check_value("GPIO_OUT", wv & OUT_MASK, rd);
			wv = next_rand(32);
			write_reg(`REG_GPIO_IRQEN, wv);
			read_reg(`REG_GPIO_IRQEN, rd);
			check_value("GPIO_IRQEN", wv & EN_MASK, rd);
			wv = next_rand(32);
			write_reg(`REG_T0_CMP, wv);
			read_reg(`REG_T0_CMP, rd);
			check_value("T0_CMP", wv, rd);
			wv = next_rand(32);
			write_reg(`REG_T1_CMP, wv);
			read_reg(`REG_T1_CMP, rd);
			check_value("T1_CMP", wv, rd);
		end
		read_reg(`REG_SYSID, rd);
		check_value("SYSID", `SYSTEM_ID, rd);
		// Other banks and unused offsets read zero
		apb_transfer(1'b0, {4'h2, `REG_SYSID, 2'b00}, 32'd0, rd);
		check_value("bank 2", 32'd0, rd);
		apb_transfer(1'b0, {4'h0, `REG_SYSID, 2'b00}, 32'd0, rd);
		check_value("bank 0", 32'd0, rd);
		read_reg(10'd10, rd);
		check_value("offset 10", 32'd0, rd);
		read_reg(10'h3ff, rd);
		check_value("offset 3ff", 32'd0, rd);
		end_test();
	endtask

	task automatic gpio_test();
		logic [31:0] rd;
		begin_test("gpio");
		// Only input 0 may interrupt
		write_reg(`REG_GPIO_IRQEN, 32'h1);
		idle_cycles(4);
		gpio_irq_cnt = 0;
		gpio_in = 3'b001;
		idle_cycles(6);
		check_value("enabled rise pulses", 32'd1, 32'(gpio_irq_cnt));
		read_reg(`REG_GPIO_IN, rd);
		check_value("GPIO_IN", 32'h1, rd);
		gpio_irq_cnt = 0;
		gpio_in = 3'b011;
		idle_cycles(6);
		check_value("disabled pulses", 32'd0, 32'(gpio_irq_cnt));
		read_reg(`REG_GPIO_IN, rd);
		check_value("GPIO_IN", 32'h3, rd);
		// Falling edge counts as a change too
		gpio_irq_cnt = 0;
		gpio_in = 3'b010;
		idle_cycles(6);
		check_value("enabled fall pulses", 32'd1, 32'(gpio_irq_cnt));
		write_reg(`REG_GPIO_IRQEN, 32'h0);
		end_test();
	endtask

	task automatic oneshot_test(input int i);
		logic [31:0] rd;
		logic [9:0]  ctrl_off;
		logic [9:0]  cmp_off;
		logic [9:0]  cnt_off;
		int          c;
		int          waited;
		logic        seen;
		begin_test((i == 0) ? "t0_oneshot" : "t1_oneshot");
		ctrl_off = (i == 0) ? `REG_T0_CTRL : `REG_T1_CTRL;
		cmp_off  = (i == 0) ? `REG_T0_CMP : `REG_T1_CMP;
		cnt_off  = (i == 0) ? `REG_T0_CNT : `REG_T1_CNT;
		c = 5 + int'(next_rand(4));
		write_reg(cmp_off, 32'(c));
		write_reg(cnt_off, 32'd0);
		tmr_irq_cnt[i] = 0;
		write_reg(ctrl_off, 32'h1);
		wait_pulse(i, 2 * c + 20, waited, seen);
		check_true(seen, "timer interrupt never arrived");
		read_reg(ctrl_off, rd);
		check_value("CTRL after match", 32'd0, rd);
		read_reg(cnt_off, rd);
		check_value("CNT after match", 32'd0, rd);
		idle_cycles(2 * c);
		check_value("pulse count", 32'd1, 32'(tmr_irq_cnt[i]));
		end_test();
	endtask

	task automatic autorestart_test(input int i);
		logic [31:0] rd;
		logic [9:0]  ctrl_off;
		logic [9:0]  cmp_off;
		logic [9:0]  cnt_off;
		int          c;
		int          waited;
		logic        seen;
		begin_test((i == 0) ? "t0_restart" : "t1_restart");
		ctrl_off = (i == 0) ? `REG_T0_CTRL : `REG_T1_CTRL;
		cmp_off  = (i == 0) ? `REG_T0_CMP : `REG_T1_CMP;
		cnt_off  = (i == 0) ? `REG_T0_CNT : `REG_T1_CNT;
		c = 4 + int'(next_rand(3));
		write_reg(cmp_off, 32'(c));
		write_reg(cnt_off, 32'd0);
		write_reg(ctrl_off, 32'h3);
		wait_pulse(i, 2 * c + 20, waited, seen);
		check_true(seen, "first timer interrupt never arrived");
		// One period is compare plus one
		for (int k = 0; k < 3; k++) begin
			wait_pulse(i, 2 * c + 20, waited, seen);
			check_value("pulse spacing", 32'(c + 1), 32'(waited));
		end
		read_reg(ctrl_off, rd);
		check_value("CTRL running", 32'h3, rd);
		write_reg(ctrl_off, 32'h0);
		end_test();
	endtask

	task automatic activity_test(input int line);
		int   high_cyc;
		logic other_lit;
		begin_test((line == 1) ? "act_rx" : "act_tx");
		high_cyc  = 0;
		other_lit = 1'b0;
		idle_cycles(1);
		// One-cycle start bit
		if (line == 1)
			uart_rxd = 1'b0;
		else
			uart_txd = 1'b0;
		idle_cycles(1);
		uart_rxd = 1'b1;
		uart_txd = 1'b1;
		for (int n = 0; n < STRETCH + 20; n++) begin
			@(negedge sys_clk);
			if (act_led[1 - line])
				other_lit = 1'b1;
			if (act_led[line])
				high_cyc++;
			else if (high_cyc > 0)
				break;
		end
		check_value("lit cycles", 32'(STRETCH), 32'(high_cyc));
		check_true(!other_lit, "the other activity LED lit up");
		idle_cycles(1);
		end_test();
	endtask

	//----------------------------------------
	// Main sequence
	//----------------------------------------
	initial begin
		rst1           = 1'b0;
		apb_req        = '0;
		gpio_in        = '0;
		// Serial lines idle high
		uart_rxd       = 1'b1;
		uart_txd       = 1'b1;
		lfsr_state     = 32'd83814;
		err_cnt        = 0;
		test_cnt       = 0;
		test_fail_cnt  = 0;
		gpio_irq_cnt   = 0;
		tmr_irq_cnt[0] = 0;
		tmr_irq_cnt[1] = 0;
		repeat (2) @(posedge sys_clk);
		#10;
		rst1 = 1'b1;

		reset_test();
		roundtrip_test();
		gpio_test();
		oneshot_test(0);
		oneshot_test(1);
		autorestart_test(0);
		autorestart_test(1);
		activity_test(1);
		activity_test(0);

		$display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
hw/sysctl_pkg.sv
hw/apb_csr_bridge.sv
hw/sysctl_timer.sv
hw/sysctl_gpio.sv
hw/activity_led.sv
hw/sysctl_top.sv
verification/tb_sysctl.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_sysctl
FILELIST  = filelist.f
MDIR      = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
